// File: logic/dmem_settings.svh
// Data-memory fabric settings
// Address and data widths, timer region decode
// Timer register offsets, response and width codes
`ifndef DMEM_SETTINGS_SVH
`define DMEM_SETTINGS_SVH

// Bus widths
`define DMEM_AW                 32
`define DMEM_DW                 32

// Timer region in the data map
`define DMEM_TIMER_BASE         32'h0049_0000
`define DMEM_TIMER_MASK         32'hFFFF_FFE0   // 32-byte window

// Timer registers, byte offsets inside the window
`define MTIMER_CTRL_OFS         5'h00           // Bit 0 enables counting
`define MTIMER_MTIME_LO_OFS     5'h08
`define MTIMER_MTIME_HI_OFS     5'h0C
`define MTIMER_CMP_LO_OFS       5'h10
`define MTIMER_CMP_HI_OFS       5'h14

// Response codes
`define DMEM_RESP_IDLE          2'd0
`define DMEM_RESP_RDY_OK        2'd1
`define DMEM_RESP_RDY_ER        2'd2

// Access width codes
`define DMEM_WIDTH_BYTE         2'd0
`define DMEM_WIDTH_HWORD        2'd1
`define DMEM_WIDTH_WORD         2'd2

`endif

// File: logic/dmem_pkg.sv
// Shared types of the data-memory fabric
// Core request and response records
// Wishbone master and slave bundles
`include "dmem_settings.svh"

package dmem_pkg;

    //------------------------------------------------------------
    // Core side
    //------------------------------------------------------------

    // One data-memory request as issued by the core
    typedef struct packed {
        logic                  cmd;     // 1 = write
        logic [1:0]            width;   // Byte, halfword or word
        logic [`DMEM_AW-1:0]   addr;
        logic [`DMEM_DW-1:0]   wdata;
    } dmem_req_t;

    // Response back to the core, resp not idle for one cycle
    typedef struct packed {
        logic [1:0]            resp;
        logic [`DMEM_DW-1:0]   rdata;   // Valid with RDY_OK on reads
    } dmem_rsp_t;

    //------------------------------------------------------------
    // Wishbone side
    //------------------------------------------------------------

    // Master outputs, stb also acts as cyc
    typedef struct packed {
        logic                  stb;
        logic                  we;
        logic [`DMEM_AW-1:0]   adr;     // Word aligned
        logic [`DMEM_DW-1:0]   dat;
        logic [3:0]            sel;     // Byte lanes
    } wb_req_t;

    // Slave returns
    typedef struct packed {
        logic [`DMEM_DW-1:0]   dat;
        logic                  ack;
        logic                  err;
    } wb_rsp_t;

endpackage

// File: logic/dmem_router.sv
// Data-memory request router
// Accepts one core request at a time and acknowledges it
// Decodes timer region against mask and pattern
// Everything outside the timer window goes to Wishbone
// Selected target response goes back to the core
`timescale 1ns/1ns
`include "dmem_settings.svh"

module dmem_router (
    input  logic                core_clk,
    input  logic                rst_i,

    // Core side
    input  logic                dmem_req_i,      // Held until ack
    input  dmem_pkg::dmem_req_t dmem_cmd_i,
    output logic                dmem_req_ack_o,  // One-cycle pulse
    output dmem_pkg::dmem_rsp_t dmem_rsp_o,

    // Target side
    output logic                tmr_req_o,       // Timer strobe
    output logic                wb_req_o,        // Bridge strobe
    output dmem_pkg::dmem_req_t fwd_cmd_o,       // Shared by both targets
    input  dmem_pkg::dmem_rsp_t tmr_rsp_i,
    input  dmem_pkg::dmem_rsp_t wb_rsp_i
);

    //------------------------------------------------------------
    // Decode and control signals
    //------------------------------------------------------------
    logic                busy;       // Request in flight
    logic                sel_tmr;    // Target of the request in flight
    logic                hit_tmr;    // Incoming address in timer window
    logic                accept;
    logic                rsp_done;
    dmem_pkg::dmem_rsp_t sel_rsp;

    // Region match on the incoming address
    assign hit_tmr = (dmem_cmd_i.addr & `DMEM_TIMER_MASK) == `DMEM_TIMER_BASE;

    // Response of the target that owns the current request
    assign sel_rsp  = sel_tmr ? tmr_rsp_i : wb_rsp_i;
    assign rsp_done = busy && (sel_rsp.resp != `DMEM_RESP_IDLE);

    // Free again on the edge that closes the response cycle
    assign accept = dmem_req_i && (!busy || rsp_done);

    //------------------------------------------------------------
    // State, acknowledge and target strobes
    //------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            busy           <= 1'b0;
            sel_tmr        <= 1'b0;
            dmem_req_ack_o <= 1'b0;
            tmr_req_o      <= 1'b0;
            wb_req_o       <= 1'b0;
        end else begin
            dmem_req_ack_o <= accept;               // Cycle after sampling
            tmr_req_o      <= accept && hit_tmr;
            wb_req_o       <= accept && !hit_tmr;
            if (accept) begin
                busy    <= 1'b1;
                sel_tmr <= hit_tmr;                 // Remember the owner
            end else if (rsp_done) begin
                busy    <= 1'b0;
            end
        end
    end

    // Request payload latched once, seen by both targets
    always_ff @(posedge core_clk) begin
        if (accept) begin
            fwd_cmd_o <= dmem_cmd_i;
        end
    end

    //------------------------------------------------------------
    // Response back to the core
    //------------------------------------------------------------
    // Straight through from the owning target
    // Only while a request is open, so a stray code never leaks
    always_comb begin
        dmem_rsp_o.rdata = sel_rsp.rdata;
        if (busy) begin
            dmem_rsp_o.resp = sel_rsp.resp;
        end else begin
            dmem_rsp_o.resp = `DMEM_RESP_IDLE;
        end
    end

endmodule

// File: logic/mtimer.sv
// Memory-mapped machine timer
// 64-bit counter on core_clk with enable in CTRL bit 0
// 64-bit compare register and registered interrupt level
// Word accesses only, one-cycle response after the strobe
`timescale 1ns/1ns
`include "dmem_settings.svh"

module mtimer (
    input  logic                core_clk,
    input  logic                rst_i,
    input  logic                req_i,          // One-cycle strobe
    input  dmem_pkg::dmem_req_t cmd_i,
    output dmem_pkg::dmem_rsp_t rsp_o,
    output logic                timer_irq_o
);

    //------------------------------------------------------------
    // Registers and access decode
    //------------------------------------------------------------
    logic                cnt_en;     // CTRL bit 0
    logic [63:0]         mtime;
    logic [63:0]         mtimecmp;
    logic [4:0]          ofs;
    logic                acc_ok;     // Mapped offset with word width
    logic                wr_en;
    logic [`DMEM_DW-1:0] rd_word;
    logic [1:0]          rsp_resp;
    logic [`DMEM_DW-1:0] rsp_rdata;

    assign ofs = cmd_i.addr[4:0];   // Offset inside the window

    // Read mux, also flags unmapped offsets
    always_comb begin
        acc_ok  = (cmd_i.width == `DMEM_WIDTH_WORD);
        rd_word = '0;
        case (ofs)
            `MTIMER_CTRL_OFS:     rd_word = {31'b0, cnt_en};
            `MTIMER_MTIME_LO_OFS: rd_word = mtime[31:0];
            `MTIMER_MTIME_HI_OFS: rd_word = mtime[63:32];
            `MTIMER_CMP_LO_OFS:   rd_word = mtimecmp[31:0];
            `MTIMER_CMP_HI_OFS:   rd_word = mtimecmp[63:32];
            default:              acc_ok  = 1'b0;   // Hole in the map
        endcase
    end

    assign wr_en = req_i && cmd_i.cmd && acc_ok;

    //------------------------------------------------------------
    // Counter, compare and control
    //------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            cnt_en   <= 1'b1;       // Counts from reset on
            mtime    <= '0;
            mtimecmp <= '1;         // Far future, no interrupt
        end else begin
            if (cnt_en) begin
                mtime <= mtime + 64'd1;
            end
            // Software write wins over the increment
            if (wr_en) begin
                case (ofs)
                    `MTIMER_CTRL_OFS:     cnt_en          <= cmd_i.wdata[0];
                    `MTIMER_MTIME_LO_OFS: mtime[31:0]     <= cmd_i.wdata;
                    `MTIMER_MTIME_HI_OFS: mtime[63:32]    <= cmd_i.wdata;
                    `MTIMER_CMP_LO_OFS:   mtimecmp[31:0]  <= cmd_i.wdata;
                    `MTIMER_CMP_HI_OFS:   mtimecmp[63:32] <= cmd_i.wdata;
                    default: ;
                endcase
            end
        end
    end

    // Interrupt level, one cycle behind the compare
    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            timer_irq_o <= 1'b0;
        end else begin
            timer_irq_o <= (mtime >= mtimecmp);
        end
    end

    //------------------------------------------------------------
    // Response
    //------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            rsp_resp <= `DMEM_RESP_IDLE;
        end else if (req_i) begin
            rsp_resp <= acc_ok ? `DMEM_RESP_RDY_OK : `DMEM_RESP_RDY_ER;
        end else begin
            rsp_resp <= `DMEM_RESP_IDLE;
        end
    end

    always_ff @(posedge core_clk) begin
        if (req_i) begin
            rsp_rdata <= rd_word;   // Zero on unmapped offsets
        end
    end

    assign rsp_o.resp  = rsp_resp;
    assign rsp_o.rdata = rsp_rdata;

endmodule

// File: logic/dmem_wb_bridge.sv
// Data-memory to Wishbone bridge
// One single-beat cycle per routed request
// Byte lanes and write data replication by access width
// Ack returns the raw slave word, err returns an error code
`timescale 1ns/1ns
`include "dmem_settings.svh"

module dmem_wb_bridge (
    input  logic                core_clk,
    input  logic                rst_i,
    input  logic                req_i,          // One-cycle strobe
    input  dmem_pkg::dmem_req_t cmd_i,
    output dmem_pkg::dmem_rsp_t rsp_o,
    output dmem_pkg::wb_req_t   wb_o,
    input  dmem_pkg::wb_rsp_t   wb_i
);

    //------------------------------------------------------------
    // Cycle registers
    //------------------------------------------------------------
    logic                stb_q;
    logic                we_q;
    logic [`DMEM_AW-1:0] adr_q;
    logic [`DMEM_DW-1:0] dat_q;
    logic [3:0]          sel_q;
    logic [3:0]          sel_c;      // Lanes for the incoming request
    logic [`DMEM_DW-1:0] dat_c;      // Replicated write data
    logic                cyc_end;
    logic [1:0]          rsp_resp;
    logic [`DMEM_DW-1:0] rsp_rdata;

    // Lane select and data replication
    always_comb begin
        case (cmd_i.width)
            `DMEM_WIDTH_BYTE: begin
                sel_c = 4'b0001 << cmd_i.addr[1:0];
                dat_c = {4{cmd_i.wdata[7:0]}};
            end
            `DMEM_WIDTH_HWORD: begin
                sel_c = cmd_i.addr[1] ? 4'b1100 : 4'b0011;   // Upper or lower half
                dat_c = {2{cmd_i.wdata[15:0]}};
            end
            default: begin
                sel_c = 4'b1111;
                dat_c = cmd_i.wdata;
            end
        endcase
    end

    // Slave closes the cycle either way
    assign cyc_end = stb_q && (wb_i.ack || wb_i.err);

    //------------------------------------------------------------
    // Strobe and response control
    //------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            stb_q    <= 1'b0;
            rsp_resp <= `DMEM_RESP_IDLE;
        end else begin
            if (req_i) begin
                stb_q <= 1'b1;      // Rises one cycle after the strobe
            end else if (cyc_end) begin
                stb_q <= 1'b0;
            end
            if (cyc_end) begin
                rsp_resp <= wb_i.ack ? `DMEM_RESP_RDY_OK : `DMEM_RESP_RDY_ER;
            end else begin
                rsp_resp <= `DMEM_RESP_IDLE;
            end
        end
    end

    // Payload held stable for the whole cycle
    always_ff @(posedge core_clk) begin
        if (req_i) begin
            adr_q <= {cmd_i.addr[`DMEM_AW-1:2], 2'b00};
            we_q  <= cmd_i.cmd;
            dat_q <= dat_c;
            sel_q <= sel_c;
        end
        if (cyc_end) begin
            rsp_rdata <= wb_i.dat;  // Raw word, core picks the lanes
        end
    end

    assign wb_o.stb    = stb_q;
    assign wb_o.we     = we_q;
    assign wb_o.adr    = adr_q;
    assign wb_o.dat    = dat_q;
    assign wb_o.sel    = sel_q;
    assign rsp_o.resp  = rsp_resp;
    assign rsp_o.rdata = rsp_rdata;

endmodule

// File: logic/dmem_fabric_top.sv
// Data-memory fabric top level
// Router in front, machine timer and Wishbone bridge behind it
`timescale 1ns/1ns

module dmem_fabric_top (
    input  logic                core_clk,
    input  logic                rst_i,

    // Core data port
    input  logic                dmem_req_i,
    input  dmem_pkg::dmem_req_t dmem_cmd_i,
    output logic                dmem_req_ack_o,
    output dmem_pkg::dmem_rsp_t dmem_rsp_o,

    // Wishbone master port
    output dmem_pkg::wb_req_t   wb_o,
    input  dmem_pkg::wb_rsp_t   wb_i,

    output logic                timer_irq_o     // Machine timer interrupt
);

    //------------------------------------------------------------
    // Router to target wiring
    //------------------------------------------------------------
    logic                tmr_req;
    logic                wb_req;
    dmem_pkg::dmem_req_t fwd_cmd;   // One registered request for both
    dmem_pkg::dmem_rsp_t tmr_rsp;
    dmem_pkg::dmem_rsp_t wb_rsp;

    dmem_router i_router (
        .core_clk       (core_clk      ),
        .rst_i          (rst_i         ),
        .dmem_req_i     (dmem_req_i    ),
        .dmem_cmd_i     (dmem_cmd_i    ),
        .dmem_req_ack_o (dmem_req_ack_o),
        .dmem_rsp_o     (dmem_rsp_o    ),
        .tmr_req_o      (tmr_req       ),
        .wb_req_o       (wb_req        ),
        .fwd_cmd_o      (fwd_cmd       ),
        .tmr_rsp_i      (tmr_rsp       ),
        .wb_rsp_i       (wb_rsp        )
    );

    // Timer window
    mtimer i_timer (
        .core_clk    (core_clk   ),
        .rst_i       (rst_i      ),
        .req_i       (tmr_req    ),
        .cmd_i       (fwd_cmd    ),
        .rsp_o       (tmr_rsp    ),
        .timer_irq_o (timer_irq_o)
    );

    // Rest of the address map
    dmem_wb_bridge i_wb_bridge (
        .core_clk (core_clk),
        .rst_i    (rst_i   ),
        .req_i    (wb_req  ),
        .cmd_i    (fwd_cmd ),
        .rsp_o    (wb_rsp  ),
        .wb_o     (wb_o    ),
        .wb_i     (wb_i    )
    );

endmodule

// File: verification/dmem_assertions.sv
// Protocol assertions for the data-memory fabric
// Acknowledge pulse, Wishbone hold until ack or err, one-cycle responses
`timescale 1ns/1ns
`include "dmem_settings.svh"

module dmem_assertions (
    input logic                core_clk,
    input logic                rst_i,
    input logic                dmem_req_i,
    input logic                dmem_req_ack_o,
    input dmem_pkg::dmem_rsp_t dmem_rsp_o,
    input dmem_pkg::wb_req_t   wb_o,
    input dmem_pkg::wb_rsp_t   wb_i
);

    // Ack only for a request still held, never twice in a row
    ack_needs_req: assert property (@(posedge core_clk) disable iff (rst_i)
        dmem_req_ack_o |-> dmem_req_i)
        else $error("dmem_req_ack_o high without dmem_req_i");

    ack_is_pulse: assert property (@(posedge core_clk) disable iff (rst_i)
        dmem_req_ack_o |=> !dmem_req_ack_o)
        else $error("dmem_req_ack_o high in two cycles in a row");

    // Open Wishbone cycle frozen until the slave ends it
    wb_hold: assert property (@(posedge core_clk) disable iff (rst_i)
        (wb_o.stb && !wb_i.ack && !wb_i.err) |=> (wb_o.stb && $stable(wb_o)))
        else $error("wb_o changed before ack or err");

    rsp_one_cycle: assert property (@(posedge core_clk) disable iff (rst_i)
        (dmem_rsp_o.resp != `DMEM_RESP_IDLE) |=> (dmem_rsp_o.resp == `DMEM_RESP_IDLE))
        else $error("dmem_rsp_o.resp not idle for more than one cycle");

endmodule

bind dmem_fabric_top dmem_assertions i_assertions (
    .core_clk       (core_clk      ),
    .rst_i          (rst_i         ),
    .dmem_req_i     (dmem_req_i    ),
    .dmem_req_ack_o (dmem_req_ack_o),
    .dmem_rsp_o     (dmem_rsp_o    ),
    .wb_o           (wb_o          ),
    .wb_i           (wb_i          )
);

// File: verification/tb_dmem_fabric.sv
// Testbench for the data-memory fabric
// Clock, reset and a Wishbone slave memory with random ack delay
// Case-file driver with ack, latency, response and interrupt checks
`timescale 1ns/1ns
`include "dmem_settings.svh"

module tb_dmem_fabric;

    localparam int MAX_CASES = 40;
    localparam int CASE_COLS = 7;       // cmd width addr wdata resp rdata flags

    logic                core_clk;
    logic                rst_i;
    logic                dmem_req_i;
    dmem_pkg::dmem_req_t dmem_cmd_i;
    logic                dmem_req_ack_o;
    dmem_pkg::dmem_rsp_t dmem_rsp_o;
    dmem_pkg::wb_req_t   wb_o;
    dmem_pkg::wb_rsp_t   wb_i;
    logic                timer_irq_o;

    logic [31:0] case_mem [0:MAX_CASES*CASE_COLS-1];
    logic [31:0] slv_mem [0:63];        // Slave storage, aliased by adr[7:2]
    logic        slv_armed;             // Delay running for the open cycle
    logic [1:0]  slv_wait;
    logic [31:0] slv_rnd;
    integer      seed;
    logic [31:0] prev_rdata;            // Last read word, for the mtime check
    int          case_idx;

    dmem_fabric_top UUT (
        .core_clk       (core_clk      ),
        .rst_i          (rst_i         ),
        .dmem_req_i     (dmem_req_i    ),
        .dmem_cmd_i     (dmem_cmd_i    ),
        .dmem_req_ack_o (dmem_req_ack_o),
        .dmem_rsp_o     (dmem_rsp_o    ),
        .wb_o           (wb_o          ),
        .wb_i           (wb_i          ),
        .timer_irq_o    (timer_irq_o   )
    );

    initial begin
        core_clk = 1'b0;
        forever #4 core_clk = ~core_clk;    // 8 ns period
    end

    //------------------------------------------------------------
    // Wishbone slave memory
    //------------------------------------------------------------
    function automatic logic [31:0] fill_word(input logic [5:0] idx);
        return {16'hA5C3, 8'h00, idx, 2'b00};   // Carries its own address
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  sel);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    initial begin : wb_slave_model
        wb_i      = '0;
        slv_armed = 1'b0;
        slv_wait  = 2'd0;
        seed      = 32'hf021;
        for (int w = 0; w < 64; w++) begin
            slv_mem[w] = fill_word(w[5:0]);
        end
        forever begin
            @(posedge core_clk);
            wb_i.ack <= 1'b0;               // Single-cycle ack or err
            wb_i.err <= 1'b0;
            if (!rst_i && wb_o.stb && !wb_i.ack && !wb_i.err) begin
                if (!slv_armed) begin
                    slv_rnd = $random(seed);
                    slv_wait  <= slv_rnd[1:0];  // 1 to 4 cycles in all
                    slv_armed <= 1'b1;
                end else if (slv_wait != 2'd0) begin
                    slv_wait <= slv_wait - 2'd1;
                end else begin
                    slv_armed <= 1'b0;
                    if (wb_o.adr >= 32'h0000_1000) begin
                        wb_i.err <= 1'b1;       // Outside the slave
                    end else begin
                        wb_i.ack <= 1'b1;
                        wb_i.dat <= slv_mem[wb_o.adr[7:2]];
                        if (wb_o.we) begin
                            slv_mem[wb_o.adr[7:2]] <=
                                merge_lanes(slv_mem[wb_o.adr[7:2]], wb_o.dat, wb_o.sel);
                        end
                    end
                end
            end
        end
    end

    //------------------------------------------------------------
    // Checks
    //------------------------------------------------------------
    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic wait_irq_level(input logic level);
        int n;
        n = 0;
        while (timer_irq_o !== level) begin
            if (n >= 10) begin
                $display("Timer interrupt did not reach level %0d within 10 cycles", level);
                stop_run();
            end
            @(negedge core_clk);
            n = n + 1;
        end
    endtask

    // One core access from case row k
    task automatic run_case(input int k);
        logic [31:0] c_cmd;
        logic [31:0] c_width;
        logic [31:0] c_addr;
        logic [31:0] c_wdata;
        logic [31:0] c_resp;
        logic [31:0] c_rdata;
        logic [31:0] c_flags;
        logic        is_tmr;
        logic        seen;
        int          lat;
        int          n;
        logic [1:0]  got_resp;
        logic [31:0] got_rdata;
        c_cmd   = case_mem[k*CASE_COLS];
        c_width = case_mem[k*CASE_COLS+1];
        c_addr  = case_mem[k*CASE_COLS+2];
        c_wdata = case_mem[k*CASE_COLS+3];
        c_resp  = case_mem[k*CASE_COLS+4];
        c_rdata = case_mem[k*CASE_COLS+5];
        c_flags = case_mem[k*CASE_COLS+6];
        is_tmr  = (c_addr & `DMEM_TIMER_MASK) == `DMEM_TIMER_BASE;
        got_resp  = `DMEM_RESP_IDLE;
        got_rdata = '0;

        @(posedge core_clk);
        dmem_req_i       <= 1'b1;
        dmem_cmd_i.cmd   <= c_cmd[0];
        dmem_cmd_i.width <= c_width[1:0];
        dmem_cmd_i.addr  <= c_addr;
        dmem_cmd_i.wdata <= c_wdata;

        lat  = 0;                           // Negedges since the drive edge
        seen = 1'b0;
        while (!seen) begin
            @(negedge core_clk);
            lat = lat + 1;
            if (dmem_req_ack_o) begin
                seen = 1'b1;
            end else if (lat >= 200) begin
                $display("No acknowledge within 200 cycles in case %0d", k);
                stop_run();
            end
        end
        check_value("ack cycles after sampling", lat - 1, 1);
        @(posedge core_clk);
        dmem_req_i <= 1'b0;                 // Request dropped after the ack

        n    = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge core_clk);
            lat = lat + 1;
            n   = n + 1;
            if (dmem_req_ack_o) begin
                $display("Second acknowledge for one request in case %0d", k);
                stop_run();
            end
            if (dmem_rsp_o.resp != `DMEM_RESP_IDLE) begin
                seen      = 1'b1;
                got_resp  = dmem_rsp_o.resp;
                got_rdata = dmem_rsp_o.rdata;
            end else if (n >= 200) begin
                $display("No response within 200 cycles in case %0d", k);
                stop_run();
            end
        end
        check_value("dmem_rsp_o.resp", 32'(got_resp), c_resp);
        if (is_tmr) begin
            check_value("timer response cycles after sampling", lat - 1, 2);
        end
        if (c_flags[0]) begin
            check_value("dmem_rsp_o.rdata", got_rdata, c_rdata);
        end
        if (c_flags[1] && got_rdata <= prev_rdata) begin
            $display("Error: dmem_rsp_o.rdata is 0x%h, not above 0x%h", got_rdata, prev_rdata);
            stop_run();
        end
        prev_rdata = got_rdata;
        if (c_flags[2]) wait_irq_level(1'b1);
        if (c_flags[3]) wait_irq_level(1'b0);
        repeat (3) begin                    // Idle gap, no stray ack
            @(negedge core_clk);
            check_value("dmem_req_ack_o", 32'(dmem_req_ack_o), 0);
        end
    endtask

    //------------------------------------------------------------
    // Main sequence
    //------------------------------------------------------------
    initial begin
        rst_i       = 1'b1;
        dmem_req_i  = 1'b0;
        dmem_cmd_i  = '0;
        prev_rdata  = '0;
        case_idx    = 0;
        for (int w = 0; w < MAX_CASES*CASE_COLS; w++) begin
            case_mem[w] = 32'hFFFF_FFFF;    // End marker where rows run out
        end
        $readmemh("verification/dmem_cases.txt", case_mem);

        repeat (8) @(posedge core_clk);
        rst_i <= 1'b0;
        @(negedge core_clk);
        check_value("timer_irq_o", 32'(timer_irq_o), 0);
        check_value("dmem_req_ack_o", 32'(dmem_req_ack_o), 0);
        check_value("dmem_rsp_o.resp", 32'(dmem_rsp_o.resp), 0);
        check_value("wb_o.stb", 32'(wb_o.stb), 0);

        while (case_idx < MAX_CASES && case_mem[case_idx*CASE_COLS] != 32'hFFFF_FFFF) begin
            run_case(case_idx);
            case_idx = case_idx + 1;
        end

        if (case_idx == 0) begin
            $display("No cases were read from the case file");
            stop_run();
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// File: verification/dmem_cases.txt
// cmd(1=wr) width(0=B 1=H 2=W) addr wdata exp_resp exp_rdata flags
// flags: 1 check rdata, 2 rdata above previous, 4 then irq high, 8 then irq low
1 2 00000000 DEADBEEF 1 00000000 0
1 2 00000004 0BADF00D 1 00000000 0
0 2 00000000 00000000 1 DEADBEEF 1
0 2 00000004 00000000 1 0BADF00D 1
1 2 00000040 11223344 1 00000000 0
1 0 00000040 FFFFFF01 1 00000000 0
1 0 00000041 000000AB 1 00000000 0
1 0 00000043 000000CD 1 00000000 0
0 2 00000040 00000000 1 CD22AB01 1
1 1 00000050 FFFF1234 1 00000000 0
1 1 00000052 0000BEEF 1 00000000 0
0 2 00000050 00000000 1 BEEF1234 1
1 2 00001000 12345678 2 00000000 0
0 2 00002000 00000000 2 00000000 0
1 2 00490010 89ABCDEF 1 00000000 0
1 2 00490014 00000001 1 00000000 0
0 2 00490010 00000000 1 89ABCDEF 1
0 2 00490014 00000000 1 00000001 1
0 2 00490008 00000000 1 00000000 0
0 2 00490008 00000000 1 00000000 2
0 1 00490008 00000000 2 00000000 0
0 2 00490004 00000000 2 00000000 0
1 2 00490014 00000000 1 00000000 0
1 2 00490010 00000000 1 00000000 4
1 2 00490000 00000000 1 00000000 0
1 2 00490014 FFFFFFFF 1 00000000 0
1 2 00490010 FFFFFFFF 1 00000000 8
0 2 00490000 00000000 1 00000000 1
FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF

// File: tb.f
+incdir+logic
logic/dmem_pkg.sv
logic/dmem_router.sv
logic/mtimer.sv
logic/dmem_wb_bridge.sv
logic/dmem_fabric_top.sv
verification/dmem_assertions.sv
verification/tb_dmem_fabric.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_dmem_fabric -Mdir obj_dir -f tb.f &&
./obj_dir/Vtb_dmem_fabric | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
